/* tb.f */
ntt_params_pkg.sv
ntt_types_pkg.sv
coeff_mem_if.sv
coeff_bank.sv
pwo_ctrl.sv
pwo_datapath.sv
pwo_top.sv
pwo_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the pointwise engine testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module pwo_tb -Mdir obj_dir -f tb.f > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vpwo_tb > "$SIM_LOG" 2>&1
run_status=$?
cat "$SIM_LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulator exited with status $run_status"
    exit 1
fi

if grep -q "Simulation PASSED" "$SIM_LOG"; then
    exit 0
fi
echo "Pass line not found in $SIM_LOG"
exit 1

/* pwo_tb.sv */
// Testbench for the pointwise engine, random operands checked against a reference model
module pwo_tb
    import ntt_params_pkg::*;
    import ntt_types_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RUN_CYCLES   = WORDS_PER_POLY * 4 + 10;   // Longest sampler gap is 4 cycles
    localparam int NUM_RUNS     = 8;                         // Includes the two rejected enables
    localparam int LOAD_CYCLES  = 2 * WORDS_PER_POLY + 4;
    localparam int READ_WORDS   = 768;                       // Two cycles per result read
    localparam int CYCLE_LIMIT  = NUM_RUNS * RUN_CYCLES + LOAD_CYCLES + 2 * READ_WORDS + 16;
    localparam int BANK_LATENCY = 68;

    logic                  clk;
    logic                  reset_i;
    logic                  zeroize_i;
    logic                  enable_i;
    logic [1:0]            mode_i;
    logic                  sampler_mode_i;
    logic                  sampler_valid_i;
    logic [WORD_W-1:0]     sampler_data_i;
    logic [MEM_ADDR_W-1:0] a_base_i;
    logic [MEM_ADDR_W-1:0] b_base_i;
    logic [MEM_ADDR_W-1:0] c_base_i;
    logic                  load_we_i;
    logic                  load_bank_i;
    logic [MEM_ADDR_W-1:0] load_addr_i;
    logic [WORD_W-1:0]     load_data_i;
    logic                  res_rd_en_i;
    logic [MEM_ADDR_W-1:0] res_rd_addr_i;
    logic [WORD_W-1:0]     res_rd_data_o;
    logic                  busy_o;
    logic                  done_o;

    coeff_word_t a_mem [MEM_DEPTH];     // Mirrors of banks A, B and C
    coeff_word_t b_mem [MEM_DEPTH];
    coeff_word_t exp_c [MEM_DEPTH];
    integer      seed;
    int          errors;
    int          checks;
    int          cycle_cnt;

    pwo_top u_pwo_top (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Hard stop in case a run hangs
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Run stopped: cycle limit of %0d reached", CYCLE_LIMIT);
            $display("Simulation FAILED");
            $finish;
        end
    end

    function automatic logic [REG_SIZE-1:0] rand_coeff();
        int unsigned r;
        r = $random(seed);
        return REG_SIZE'(r % 32'(DILITHIUM_Q));
    endfunction

    // Lane by lane reference for one result word
    function automatic coeff_word_t model_word(pwo_mode_e mode, coeff_word_t a, coeff_word_t b);
        coeff_word_t     r;
        longint unsigned av;
        longint unsigned bv;
        longint unsigned q;
        q = longint'(DILITHIUM_Q);
        for (int l = 0; l < COEFFS_PER_WORD; l++) begin
            av = longint'(a[l]);
            bv = longint'(b[l]);
            case (mode)
                pwa:     r[l] = REG_SIZE'((av + bv) % q);
                pws:     r[l] = REG_SIZE'((av + q - bv) % q);
                default: r[l] = REG_SIZE'((av * bv) % q);
            endcase
        end
        return r;
    endfunction

    task automatic load_word(input logic bank, input int addr, input coeff_word_t data);
        @(posedge clk);
        load_we_i   <= 1'b1;
        load_bank_i <= bank;
        load_addr_i <= MEM_ADDR_W'(addr);
        load_data_i <= data;
    endtask

    task automatic start_run(input logic [1:0] mode, input int a_base, input int b_base,
                             input int c_base, input logic smode);
        @(posedge clk);
        enable_i       <= 1'b1;
        mode_i         <= mode;
        sampler_mode_i <= smode;
        a_base_i       <= MEM_ADDR_W'(a_base);
        b_base_i       <= MEM_ADDR_W'(b_base);
        c_base_i       <= MEM_ADDR_W'(c_base);
        @(posedge clk);
        enable_i <= 1'b0;
    endtask

    // Edges counted from the one that drove enable
    task automatic wait_done(output int cycles);
        bit seen;
        seen = 1'b0;
        cycles = 1;
        while (!seen && cycles < RUN_CYCLES) begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
            seen = done_o;
            checks++;
            assert (seen || busy_o) else begin
                errors++;
                $display("CHECK FAILED at %0t: busy_o low before done_o", $time);
            end
        end
        assert (seen) else begin
            errors++;
            $display("No done_o pulse came within %0d cycles of the enable", RUN_CYCLES);
        end
        if (seen) begin
            @(negedge clk);
            checks++;
            assert (!done_o) else begin
                errors++;
                $display("CHECK FAILED at %0t: done_o longer than one cycle", $time);
            end
        end
    endtask

    task automatic apply_model(input pwo_mode_e mode, input int a_base, input int b_base,
                               input int c_base);
        for (int i = 0; i < WORDS_PER_POLY; i++) begin
            exp_c[c_base + i] = model_word(mode, a_mem[a_base + i], b_mem[b_base + i]);
        end
    endtask

    task automatic run_bank(input pwo_mode_e mode, input int a_base, input int b_base,
                            input int c_base);
        int cycles;
        start_run(mode, a_base, b_base, c_base, 1'b0);
        wait_done(cycles);
        checks++;
        assert (cycles == BANK_LATENCY) else begin
            errors++;
            $display("CHECK FAILED at %0t: done_o after %0d cycles, expected %0d",
                     $time, cycles, BANK_LATENCY);
        end
        apply_model(mode, a_base, b_base, c_base);
    endtask

    // B words come from the stream, with random idle gaps
    task automatic run_sampler(input int a_base, input int c_base);
        coeff_word_t samp [WORDS_PER_POLY];
        int          gap;
        int          cycles;
        for (int i = 0; i < WORDS_PER_POLY; i++) begin
            for (int l = 0; l < COEFFS_PER_WORD; l++) begin
                samp[i][l] = rand_coeff();
            end
        end
        start_run(pwm, a_base, 0, c_base, 1'b1);
        for (int i = 0; i < WORDS_PER_POLY; i++) begin
            gap = int'($unsigned($random(seed)) % 32'd4);
            repeat (gap) begin
                @(posedge clk);
                sampler_valid_i <= 1'b0;
                sampler_data_i  <= {$random(seed), $random(seed), $random(seed)};
            end
            @(posedge clk);
            sampler_valid_i <= 1'b1;
            sampler_data_i  <= samp[i];
        end
        @(posedge clk);
        sampler_valid_i <= 1'b0;
        wait_done(cycles);
        for (int i = 0; i < WORDS_PER_POLY; i++) begin
            exp_c[c_base + i] = model_word(pwm, a_mem[a_base + i], samp[i]);
        end
    endtask

    task automatic check_c(input int first, input int count, input string what);
        for (int i = 0; i < count; i++) begin
            @(posedge clk);
            res_rd_en_i   <= 1'b1;
            res_rd_addr_i <= MEM_ADDR_W'(first + i);
            @(posedge clk);
            res_rd_en_i <= 1'b0;
            @(negedge clk);
            checks++;
            assert (res_rd_data_o == exp_c[first + i]) else begin
                errors++;
                $display("CHECK FAILED at %0t: %s C[%0d] got %h expected %h",
                         $time, what, first + i, res_rd_data_o, exp_c[first + i]);
            end
        end
    endtask

    task automatic check_quiet(input int n, input string what);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            checks++;
            assert (!done_o && !busy_o) else begin
                errors++;
                $display("CHECK FAILED at %0t: %s left busy_o or done_o high", $time, what);
            end
        end
    endtask

    initial begin
        int cycles;
        seed = 32'h9420;
        errors = 0;
        checks = 0;
        reset_i         <= 1'b1;
        zeroize_i       <= 1'b0;
        enable_i        <= 1'b0;
        mode_i          <= 2'd0;
        sampler_mode_i  <= 1'b0;
        sampler_valid_i <= 1'b0;
        sampler_data_i  <= '0;
        a_base_i        <= '0;
        b_base_i        <= '0;
        c_base_i        <= '0;
        load_we_i       <= 1'b0;
        load_bank_i     <= 1'b0;
        load_addr_i     <= '0;
        load_data_i     <= '0;
        res_rd_en_i     <= 1'b0;
        res_rd_addr_i   <= '0;
        repeat (4) @(posedge clk);
        reset_i <= 1'b0;
        @(negedge clk);
        checks++;
        assert (!busy_o && !done_o) else begin
            errors++;
            $display("CHECK FAILED at %0t: busy_o or done_o high after reset", $time);
        end

        // A in slot 0, B in slot 1, a few edge lanes at word 0
        for (int i = 0; i < WORDS_PER_POLY; i++) begin
            for (int l = 0; l < COEFFS_PER_WORD; l++) begin
                a_mem[i][l]      = rand_coeff();
                b_mem[64 + i][l] = rand_coeff();
            end
        end
        a_mem[0][0]  = '0;
        b_mem[64][0] = DILITHIUM_Q - 24'd1;
        a_mem[0][1]  = DILITHIUM_Q - 24'd1;
        b_mem[64][1] = DILITHIUM_Q - 24'd1;
        for (int i = 0; i < WORDS_PER_POLY; i++) begin
            load_word(1'b0, i, a_mem[i]);
            load_word(1'b1, 64 + i, b_mem[64 + i]);
        end
        @(posedge clk);
        load_we_i <= 1'b0;

        run_bank(pwm, 0, 64, 128);
        check_c(128, 64, "pwm");
        run_bank(pwa, 0, 64, 192);
        check_c(192, 64, "pwa");
        run_bank(pws, 0, 64, 128);
        check_c(128, 64, "pws");
        run_sampler(0, 192);
        check_c(192, 64, "sampler pwm");

        // Second enable lands mid-run
        start_run(pwa, 0, 64, 128, 1'b0);
        repeat (10) @(posedge clk);
        start_run(pwm, 0, 64, 192, 1'b0);
        wait_done(cycles);
        apply_model(pwa, 0, 64, 128);
        check_quiet(80, "enable while busy");
        check_c(128, 64, "pwa with busy enable");
        check_c(192, 64, "C after busy enable");

        start_run(2'd3, 0, 64, 128, 1'b0);
        check_quiet(80, "mode 3 enable");
        check_c(128, 64, "C after mode 3 enable");

        @(posedge clk);
        zeroize_i <= 1'b1;
        @(posedge clk);
        zeroize_i <= 1'b0;
        for (int i = 0; i < MEM_DEPTH; i++) begin
            a_mem[i] = '0;
            b_mem[i] = '0;
            exp_c[i] = '0;
        end
        check_c(0, MEM_DEPTH, "zeroize");
        run_bank(pwa, 0, 64, 128);
        check_c(128, 64, "pwa after zeroize");

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* pwo_top.sv */
// Pointwise engine top with operand banks A and B, result bank C, sequencer and datapath
module pwo_top
    import ntt_params_pkg::*;
    import ntt_types_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  zeroize_i,
    input  logic                  enable_i,
    input  logic [1:0]            mode_i,
    input  logic                  sampler_mode_i,
    input  logic                  sampler_valid_i,
    input  logic [WORD_W-1:0]     sampler_data_i,
    input  logic [MEM_ADDR_W-1:0] a_base_i,
    input  logic [MEM_ADDR_W-1:0] b_base_i,
    input  logic [MEM_ADDR_W-1:0] c_base_i,
    input  logic                  load_we_i,
    input  logic                  load_bank_i,    // 0 loads A, 1 loads B
    input  logic [MEM_ADDR_W-1:0] load_addr_i,
    input  logic [WORD_W-1:0]     load_data_i,
    input  logic                  res_rd_en_i,
    input  logic [MEM_ADDR_W-1:0] res_rd_addr_i,
    output logic [WORD_W-1:0]     res_rd_data_o,
    output logic                  busy_o,
    output logic                  done_o
);

    coeff_mem_if a_if ();
    coeff_mem_if b_if ();
    coeff_mem_if c_if ();

    pwo_mode_e             mode_in;
    logic                  issue;
    logic [WORD_IDX_W-1:0] word_idx;
    pwo_mode_e             run_mode;
    logic                  sampler_sel;
    logic [MEM_ADDR_W-1:0] run_c_base;

    assign mode_in = pwo_mode_e'(mode_i);   // Encoding 3 is rejected by the sequencer

    // Outer load port onto the write side of A or B
    assign a_if.wr_en   = load_we_i && !load_bank_i;
    assign a_if.wr_addr = load_addr_i;
    assign a_if.wr_data = load_data_i;
    assign b_if.wr_en   = load_we_i && load_bank_i;
    assign b_if.wr_addr = load_addr_i;
    assign b_if.wr_data = load_data_i;

    // Outer result port onto the read side of C
    assign c_if.rd_en   = res_rd_en_i;
    assign c_if.rd_addr = res_rd_addr_i;
    assign res_rd_data_o = c_if.rd_data;

    coeff_bank u_bank_a (
        .clk       (clk),
        .reset_i   (reset_i),
        .zeroize_i (zeroize_i),
        .mem_port  (a_if.mem)
    );

    coeff_bank u_bank_b (
        .clk       (clk),
        .reset_i   (reset_i),
        .zeroize_i (zeroize_i),
        .mem_port  (b_if.mem)
    );

    coeff_bank u_bank_c (
        .clk       (clk),
        .reset_i   (reset_i),
        .zeroize_i (zeroize_i),
        .mem_port  (c_if.mem)
    );

    pwo_ctrl u_pwo_ctrl (
        .clk             (clk),
        .reset_i         (reset_i),
        .zeroize_i       (zeroize_i),
        .enable_i        (enable_i),
        .mode_i          (mode_in),
        .sampler_mode_i  (sampler_mode_i),
        .sampler_valid_i (sampler_valid_i),
        .a_base_i        (a_base_i),
        .b_base_i        (b_base_i),
        .c_base_i        (c_base_i),
        .a_rd            (a_if.reader),
        .b_rd            (b_if.reader),
        .issue_o         (issue),
        .word_idx_o      (word_idx),
        .mode_o          (run_mode),
        .sampler_sel_o   (sampler_sel),
        .c_base_o        (run_c_base),
        .busy_o          (busy_o),
        .done_o          (done_o)
    );

    // A and B arrive together one cycle after issue
    pwo_datapath u_pwo_datapath (
        .clk            (clk),
        .reset_i        (reset_i),
        .issue_i        (issue),
        .word_idx_i     (word_idx),
        .mode_i         (run_mode),
        .sampler_sel_i  (sampler_sel),
        .sampler_data_i (sampler_data_i),
        .c_base_i       (run_c_base),
        .a_rd_data      (a_if.rd_data),
        .b_rd_data      (b_if.rd_data),
        .c_wr           (c_if.writer)
    );

endmodule

/* pwo_datapath.sv */
// Four-lane pointwise multiply, add and subtract modulo q with result write into bank C
module pwo_datapath
    import ntt_params_pkg::*;
    import ntt_types_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  issue_i,
    input  logic [WORD_IDX_W-1:0] word_idx_i,
    input  pwo_mode_e             mode_i,
    input  logic                  sampler_sel_i,
    input  coeff_word_t           sampler_data_i,
    input  logic [MEM_ADDR_W-1:0] c_base_i,
    input  coeff_word_t           a_rd_data,
    input  coeff_word_t           b_rd_data,
    coeff_mem_if.writer           c_wr
);

    coeff_word_t           samp_q;         // Lines up with the A read data
    logic                  rd_vld_q;
    logic [WORD_IDX_W-1:0] rd_idx_q;
    logic                  s1_vld_q;
    logic [WORD_IDX_W-1:0] s1_idx_q;
    pwo_mode_e             s1_mode_q;
    coeff_word_t           red_w;          // Stage 2 reduced lanes
    logic                  wr_en_q;
    logic [MEM_ADDR_W-1:0] wr_addr_q;
    coeff_word_t           wr_data_q;

    // Valid chain, read then stage 1 then write
    always_ff @(posedge clk) begin
        if (reset_i) begin
            rd_vld_q <= 1'b0;
            s1_vld_q <= 1'b0;
            wr_en_q  <= 1'b0;
        end else begin
            rd_vld_q <= issue_i;
            s1_vld_q <= rd_vld_q;
            wr_en_q  <= s1_vld_q;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_i) begin
            samp_q <= sampler_data_i;
        end
        rd_idx_q  <= word_idx_i;
        s1_idx_q  <= rd_idx_q;
        s1_mode_q <= mode_i;
        wr_addr_q <= c_base_i + MEM_ADDR_W'(s1_idx_q);
        wr_data_q <= red_w;
    end

    for (genvar l = 0; l < COEFFS_PER_WORD; l++) begin : g_lane
        logic [REG_SIZE-1:0]   op_a;
        logic [REG_SIZE-1:0]   op_b;
        logic [2*REG_SIZE-1:0] s1_d;
        logic [2*REG_SIZE-1:0] s1_q;       // Sum, offset difference or full product

        assign op_a = a_rd_data[l];
        assign op_b = sampler_sel_i ? samp_q[l] : b_rd_data[l];

        // Stage 1
        always_comb begin
            case (mode_i)
                pwa:     s1_d = (2*REG_SIZE)'(op_a) + (2*REG_SIZE)'(op_b);
                pws:     s1_d = (2*REG_SIZE)'(op_a) + (2*REG_SIZE)'(DILITHIUM_Q)
                                - (2*REG_SIZE)'(op_b);
                default: s1_d = (2*REG_SIZE)'(op_a) * (2*REG_SIZE)'(op_b);
            endcase
        end

        always_ff @(posedge clk) begin
            s1_q <= s1_d;
        end

        // Stage 2, add and subtract stay below 2q
        always_comb begin
            if (s1_mode_q == pwm) begin
                red_w[l] = REG_SIZE'(s1_q % (2*REG_SIZE)'(DILITHIUM_Q));
            end else if (s1_q >= (2*REG_SIZE)'(DILITHIUM_Q)) begin
                red_w[l] = REG_SIZE'(s1_q - (2*REG_SIZE)'(DILITHIUM_Q));
            end else begin
                red_w[l] = REG_SIZE'(s1_q);
            end
        end

        lane_below_q_a: assert property (
            @(posedge clk) disable iff (reset_i)
            wr_en_q |-> (wr_data_q[l] < DILITHIUM_Q)
        );
    end

    assign c_wr.wr_en   = wr_en_q;
    assign c_wr.wr_addr = wr_addr_q;
    assign c_wr.wr_data = wr_data_q;

endmodule

/* pwo_ctrl.sv */
// Sequencer that walks operand addresses, tracks words in flight and pulses done
module pwo_ctrl
    import ntt_params_pkg::*;
    import ntt_types_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  zeroize_i,
    input  logic                  enable_i,
    input  pwo_mode_e             mode_i,
    input  logic                  sampler_mode_i,
    input  logic                  sampler_valid_i,
    input  logic [MEM_ADDR_W-1:0] a_base_i,
    input  logic [MEM_ADDR_W-1:0] b_base_i,
    input  logic [MEM_ADDR_W-1:0] c_base_i,
    coeff_mem_if.reader           a_rd,
    coeff_mem_if.reader           b_rd,
    output logic                  issue_o,
    output logic [WORD_IDX_W-1:0] word_idx_o,
    output pwo_mode_e             mode_o,
    output logic                  sampler_sel_o,
    output logic [MEM_ADDR_W-1:0] c_base_o,
    output logic                  busy_o,
    output logic                  done_o
);

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_drain
    } ctrl_state_e;

    ctrl_state_e           state_q;
    logic [WORD_IDX_W-1:0] word_cnt_q;
    logic [2:0]            inflight_q;     // Bit 0 read, bit 1 stage 1, bit 2 write
    logic                  done_q;
    logic                  start;
    logic                  last_word;
    logic                  last_out;

    // Run settings captured at start
    pwo_mode_e             mode_q;
    logic                  sampler_q;
    logic [MEM_ADDR_W-1:0] a_base_q;
    logic [MEM_ADDR_W-1:0] b_base_q;
    logic [MEM_ADDR_W-1:0] c_base_q;

    assign busy_o = (state_q != st_idle) || done_q;   // Also covers the done cycle
    assign start = enable_i && !busy_o && (mode_i inside {pwm, pwa, pws});

    // Sampler mode issues only on accepted stream words
    assign issue_o = (state_q == st_run) && (!sampler_q || sampler_valid_i);
    assign last_word = (word_cnt_q == WORD_IDX_W'(WORDS_PER_POLY - 1));
    assign last_out = (state_q == st_drain) && (inflight_q == 3'b100);

    always_ff @(posedge clk) begin
        if (reset_i || zeroize_i) begin
            state_q    <= st_idle;
            word_cnt_q <= '0;
            inflight_q <= '0;
            done_q     <= 1'b0;
        end else begin
            inflight_q <= {inflight_q[1:0], issue_o};
            done_q     <= last_out;
            case (state_q)
                st_idle: begin
                    if (start) begin
                        state_q    <= st_run;
                        word_cnt_q <= '0;
                    end
                end
                st_run: begin
                    if (issue_o) begin
                        word_cnt_q <= word_cnt_q + WORD_IDX_W'(1);
                        if (last_word) begin
                            state_q <= st_drain;
                        end
                    end
                end
                st_drain: begin
                    if (last_out) begin    // Final word is in its write cycle
                        state_q <= st_idle;
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mode_q    <= mode_i;
            sampler_q <= sampler_mode_i;
            a_base_q  <= a_base_i;
            b_base_q  <= b_base_i;
            c_base_q  <= c_base_i;
        end
    end

    // B stays quiet while the sampler feeds the datapath
    assign a_rd.rd_en   = issue_o;
    assign a_rd.rd_addr = a_base_q + MEM_ADDR_W'(word_cnt_q);
    assign b_rd.rd_en   = issue_o && !sampler_q;
    assign b_rd.rd_addr = b_base_q + MEM_ADDR_W'(word_cnt_q);

    assign word_idx_o    = word_cnt_q;
    assign mode_o        = mode_q;
    assign sampler_sel_o = sampler_q;
    assign c_base_o      = c_base_q;
    assign done_o        = done_q;

    // Done only once the last issued word has cleared its write cycle
    done_drained_a: assert property (
        @(posedge clk) disable iff (reset_i)
        done_o |-> $past(issue_o && last_word, 4)
    );

endmodule

/* coeff_bank.sv */
// Coefficient bank with one read and one write port per cycle and a full-array clear
module coeff_bank
    import ntt_params_pkg::*;
    import ntt_types_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  logic      zeroize_i,
    coeff_mem_if.mem  mem_port
);

    coeff_word_t mem_q [MEM_DEPTH];
    coeff_word_t rd_data_q;        // Holds until the next read

    assign mem_port.rd_data = rd_data_q;

    // Read before write on the same address gives the old word
    always_ff @(posedge clk) begin
        if (zeroize_i) begin
            for (int i = 0; i < MEM_DEPTH; i++) begin
                mem_q[i] <= '0;
            end
            rd_data_q <= '0;
        end else begin
            if (mem_port.wr_en) begin
                mem_q[mem_port.wr_addr] <= mem_port.wr_data;
            end
            if (mem_port.rd_en) begin
                rd_data_q <= mem_q[mem_port.rd_addr];
            end
        end
    end

    // Enabled accesses need a resolved address
    rd_addr_known_a: assert property (
        @(posedge clk) disable iff (reset_i)
        mem_port.rd_en |-> !$isunknown(mem_port.rd_addr)
    );

    wr_addr_known_a: assert property (
        @(posedge clk) disable iff (reset_i)
        mem_port.wr_en |-> !$isunknown(mem_port.wr_addr)
    );

endmodule

/* coeff_mem_if.sv */
// Read and write port bundle of one coefficient bank
interface coeff_mem_if
    import ntt_params_pkg::*;
    import ntt_types_pkg::*;
();

    // Read side, data returns one cycle after rd_en
    logic                  rd_en;
    logic [MEM_ADDR_W-1:0] rd_addr;
    coeff_word_t           rd_data;

    // Write side
    logic                  wr_en;
    logic [MEM_ADDR_W-1:0] wr_addr;
    coeff_word_t           wr_data;

    // The bank itself
    modport mem (
        input  rd_en, rd_addr, wr_en, wr_addr, wr_data,
        output rd_data
    );

    // Operand fetch by the sequencer
    modport reader (
        output rd_en, rd_addr,
        input  rd_data
    );

    // Result write by the datapath
    modport writer (
        output wr_en, wr_addr, wr_data
    );

    // Outer load and result access, only one side used per bank
    modport loader (
        output wr_en, wr_addr, wr_data, rd_en, rd_addr,
        input  rd_data
    );

endinterface

/* ntt_types_pkg.sv */
// Mode encoding and memory word type shared by the pointwise engine
package ntt_types_pkg;

    import ntt_params_pkg::*;

    // Pointwise operation, encoding 3 is not a valid mode
    typedef enum logic [1:0] {
        pwm = 2'd0,     // a * b mod q
        pwa = 2'd1,     // a + b mod q
        pws = 2'd2      // a - b mod q
    } pwo_mode_e;

    // One bank word, lane 0 sits in the low bits
    typedef logic [COEFFS_PER_WORD-1:0][REG_SIZE-1:0] coeff_word_t;

endpackage

/* ntt_params_pkg.sv */
// Numeric constants of the Dilithium pointwise engine
package ntt_params_pkg;

    // Coefficient and modulus
    localparam int REG_SIZE = 24;                   // Bits per coefficient
    localparam logic [REG_SIZE-1:0] DILITHIUM_Q = 24'd8380417; // q = 2^23 - 2^13 + 1

    // Memory word layout
    localparam int COEFFS_PER_WORD = 4;
    localparam int WORD_W = COEFFS_PER_WORD * REG_SIZE; // 96 bits

    // Polynomial geometry
    localparam int DILITHIUM_N = 256;               // Coefficients per polynomial
    localparam int WORDS_PER_POLY = DILITHIUM_N / COEFFS_PER_WORD;
    localparam int WORD_IDX_W = $clog2(WORDS_PER_POLY);

    // Bank geometry, four polynomial slots per bank
    localparam int MEM_ADDR_W = 8;
    localparam int MEM_DEPTH = 1 << MEM_ADDR_W;

endpackage
